// ==== hdl/jedro_1_pkg.sv ====
package jedro_1_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Register and operand value
  typedef logic [31:0] data_t;
  // Raw instruction word
  typedef logic [31:0] instr_t;
  // Register index, full RV32I width
  typedef logic [4:0]  reg_addr_t;
  // ALU operation select
  typedef logic [3:0]  alu_op_t;

  //////////////////////////////////////////////////
  // ALU operation codes
  //////////////////////////////////////////////////

  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  // Operand B straight through, for LUI
  localparam alu_op_t ALU_PASSB = 4'd10;

  //////////////////////////////////////////////////
  // RV32I encodings
  //////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 field values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 field values
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// ==== hdl/jedro_1_decoder.sv ====
module jedro_1_decoder #(
  parameter int unsigned REG_ADDR_WIDTH = 5
) (
  input  logic                  instr_valid_i,
  input  jedro_1_pkg::instr_t    instr_i,

  // Register addresses
  output jedro_1_pkg::reg_addr_t rs1_addr_o,
  output jedro_1_pkg::reg_addr_t rs2_addr_o,
  output jedro_1_pkg::reg_addr_t rd_addr_o,

  // ALU controls
  output jedro_1_pkg::data_t     imm_o,
  output logic                  use_imm_o,
  output jedro_1_pkg::alu_op_t   alu_op_o,

  // Writeback request
  output logic                  wb_o
);

  import jedro_1_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  data_t      imm_i_type;
  data_t      imm_u_type;
  logic       legal;

  // True when the index exists in this register file
  function automatic logic reg_in_range(reg_addr_t addr);
    return int'(addr) < NUM_REGS;
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rd_addr_o  = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  // Sign extended 12-bit immediate
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  // Upper 20 bits, low 12 zero
  assign imm_u_type = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////
  // Opcode and function decode
  //////////////////////////////////////////////////

  always_comb begin
    imm_o     = imm_i_type;
    use_imm_o = 1'b0;
    alu_op_o  = ALU_ADD;
    legal     = 1'b0;

    case (opcode)
      OPC_LUI: begin
        imm_o     = imm_u_type;
        use_imm_o = 1'b1;
        alu_op_o  = ALU_PASSB;
        // Only rd is a register here
        legal     = reg_in_range(rd_addr_o);
      end

      OPC_OP_IMM: begin
        use_imm_o = 1'b1;
        legal     = reg_in_range(rd_addr_o) && reg_in_range(rs1_addr_o);
        case (funct3)
          F3_ADD_SUB: alu_op_o = ALU_ADD;
          F3_SLT:     alu_op_o = ALU_SLT;
          F3_SLTU:    alu_op_o = ALU_SLTU;
          F3_XOR:     alu_op_o = ALU_XOR;
          F3_OR:      alu_op_o = ALU_OR;
          F3_AND:     alu_op_o = ALU_AND;
          F3_SLL: begin
            alu_op_o = ALU_SLL;
            // Shift immediates carry funct7 in the upper imm bits
            if (funct7 != F7_BASE) legal = 1'b0;
          end
          default: begin
            // SRLI or SRAI, chosen by funct7
            alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            if (funct7 != F7_BASE && funct7 != F7_ALT) legal = 1'b0;
          end
        endcase
      end

      OPC_OP: begin
        legal = reg_in_range(rd_addr_o) && reg_in_range(rs1_addr_o)
                && reg_in_range(rs2_addr_o);
        case (funct3)
          F3_ADD_SUB: alu_op_o = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op_o = ALU_SLL;
          F3_SLT:     alu_op_o = ALU_SLT;
          F3_SLTU:    alu_op_o = ALU_SLTU;
          F3_XOR:     alu_op_o = ALU_XOR;
          F3_SRL_SRA: alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op_o = ALU_OR;
          default:    alu_op_o = ALU_AND;
        endcase
        // Alternate funct7 only for SUB and SRA
        if (funct7 == F7_ALT) begin
          if (funct3 != F3_ADD_SUB && funct3 != F3_SRL_SRA) legal = 1'b0;
        end else if (funct7 != F7_BASE) begin
          legal = 1'b0;
        end
      end

      // Anything else retires without writeback
      default: legal = 1'b0;
    endcase
  end

  assign wb_o = instr_valid_i && legal;

endmodule

// ==== hdl/jedro_1_regfile.sv ====
module jedro_1_regfile #(
  parameter int unsigned REG_ADDR_WIDTH = 5
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // Read port A
  input  jedro_1_pkg::reg_addr_t rpa_addr_i,
  output jedro_1_pkg::data_t     rpa_data_o,

  // Read port B
  input  jedro_1_pkg::reg_addr_t rpb_addr_i,
  output jedro_1_pkg::data_t     rpb_data_o,

  // Write port C
  input  jedro_1_pkg::reg_addr_t wpc_addr_i,
  input  jedro_1_pkg::data_t     wpc_data_i,
  input  logic                  wpc_we_i,

  // Destination and writeback buffer
  input  jedro_1_pkg::reg_addr_t reg_alu_dest_i,
  output jedro_1_pkg::reg_addr_t reg_alu_dest_o,
  input  logic                  reg_alu_wb_i,
  output logic                  reg_alu_wb_o
);

  import jedro_1_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

  // x0 up to the last implemented register
  data_t regs [NUM_REGS];

  // Asynchronous reads on the low index bits
  assign rpa_data_o = regs[rpa_addr_i[REG_ADDR_WIDTH-1:0]];
  assign rpb_data_o = regs[rpb_addr_i[REG_ADDR_WIDTH-1:0]];

  //////////////////////////////////////////////////
  // Register write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wpc_we_i && (wpc_addr_i != '0)) begin
      // x0 never written, stays zero
      regs[wpc_addr_i[REG_ADDR_WIDTH-1:0]] <= wpc_data_i;
    end
  end

  // One cycle delay, aligned with the ALU result
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      reg_alu_dest_o <= '0;
      reg_alu_wb_o   <= 1'b0;
    end else begin
      reg_alu_dest_o <= reg_alu_dest_i;
      reg_alu_wb_o   <= reg_alu_wb_i;
    end
  end

endmodule

// ==== hdl/jedro_1_alu.sv ====
module jedro_1_alu (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // Source addresses for the bypass compare
  input  jedro_1_pkg::reg_addr_t rs1_addr_i,
  input  jedro_1_pkg::reg_addr_t rs2_addr_i,

  // Register file operands and immediate
  input  jedro_1_pkg::data_t     rs1_data_i,
  input  jedro_1_pkg::data_t     rs2_data_i,
  input  jedro_1_pkg::data_t     imm_i,
  input  logic                  use_imm_i,
  input  jedro_1_pkg::alu_op_t   alu_op_i,

  // Pending write of the previous instruction
  input  jedro_1_pkg::reg_addr_t fwd_dest_i,
  input  logic                  fwd_wb_i,

  output jedro_1_pkg::data_t     result_o
);

  import jedro_1_pkg::*;

  logic       fwd_a;
  logic       fwd_b;
  data_t      op_a;
  data_t      rs2_val;
  data_t      op_b;
  logic [4:0] shamt;
  data_t      result_d;

  //////////////////////////////////////////////////
  // Bypass and operand select
  //////////////////////////////////////////////////

  // Result not yet in the register file, x0 never forwarded
  assign fwd_a = fwd_wb_i && (fwd_dest_i == rs1_addr_i) && (rs1_addr_i != '0);
  assign fwd_b = fwd_wb_i && (fwd_dest_i == rs2_addr_i) && (rs2_addr_i != '0);

  assign op_a    = fwd_a ? result_o : rs1_data_i;
  assign rs2_val = fwd_b ? result_o : rs2_data_i;

  // Immediate replaces rs2 for OP-IMM and LUI
  assign op_b = use_imm_i ? imm_i : rs2_val;

  // Shift amount from the low five bits
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD:   result_d = op_a + op_b;
      ALU_SUB:   result_d = op_a - op_b;
      ALU_SLL:   result_d = op_a << shamt;
      ALU_SLT:   result_d = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:  result_d = {31'b0, op_a < op_b};
      ALU_XOR:   result_d = op_a ^ op_b;
      ALU_SRL:   result_d = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:   result_d = data_t'($signed(op_a) >>> shamt);
      ALU_OR:    result_d = op_a | op_b;
      ALU_AND:   result_d = op_a & op_b;
      ALU_PASSB: result_d = op_b;
      // Unused codes
      default:   result_d = '0;
    endcase
  end

  // Result register, also the bypass source
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      result_o <= '0;
    end else begin
      result_o <= result_d;
    end
  end

endmodule

// ==== hdl/jedro_1_datapath.sv ====
module jedro_1_datapath #(
  parameter int unsigned REG_ADDR_WIDTH = 5
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // Instruction in
  input  logic                  instr_valid_i,
  input  jedro_1_pkg::instr_t    instr_i,

  // Retired writeback trace
  output logic                  wb_valid_o,
  output jedro_1_pkg::reg_addr_t wb_rd_o,
  output jedro_1_pkg::data_t     wb_data_o
);

  import jedro_1_pkg::*;

  // Decode outputs
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  data_t     imm;
  logic      use_imm;
  alu_op_t   alu_op;
  logic      dec_wb;

  // Register read data
  data_t     rpa_data;
  data_t     rpb_data;

  // Execute stage, one cycle after decode
  reg_addr_t reg_alu_dest;
  logic      reg_alu_wb;
  data_t     alu_result;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  jedro_1_decoder #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rd_addr_o     (rd_addr),
    .imm_o         (imm),
    .use_imm_o     (use_imm),
    .alu_op_o      (alu_op),
    .wb_o          (dec_wb)
  );

  // Write port fed back from the execute stage
  jedro_1_regfile #(
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_regfile (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .rpa_addr_i     (rs1_addr),
    .rpa_data_o     (rpa_data),
    .rpb_addr_i     (rs2_addr),
    .rpb_data_o     (rpb_data),
    .wpc_addr_i     (reg_alu_dest),
    .wpc_data_i     (alu_result),
    .wpc_we_i       (reg_alu_wb),
    .reg_alu_dest_i (rd_addr),
    .reg_alu_dest_o (reg_alu_dest),
    .reg_alu_wb_i   (dec_wb),
    .reg_alu_wb_o   (reg_alu_wb)
  );

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  jedro_1_alu u_alu (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_i (rpa_data),
    .rs2_data_i (rpb_data),
    .imm_i      (imm),
    .use_imm_i  (use_imm),
    .alu_op_i   (alu_op),
    .fwd_dest_i (reg_alu_dest),
    .fwd_wb_i   (reg_alu_wb),
    .result_o   (alu_result)
  );

  // Trace mirrors the pending register write
  assign wb_valid_o = reg_alu_wb;
  assign wb_rd_o    = reg_alu_dest;
  assign wb_data_o  = alu_result;

endmodule

// ==== sim/jedro_1_tb.sv ====
module jedro_1_tb;

  import jedro_1_pkg::*;

  localparam int MAX_ROWS     = 96;
  localparam int IDLE_TIMEOUT = 20;

  logic      clk_i;
  logic      rstn_i;
  logic      instr_valid_i;
  instr_t    instr_i;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  data_t     wb_data_o;

  // Stimulus table, one row per instruction
  instr_t    tbl_instr [MAX_ROWS];
  logic      tbl_valid [MAX_ROWS];
  reg_addr_t tbl_rd    [MAX_ROWS];
  data_t     tbl_data  [MAX_ROWS];
  // Row follows the previous one with no bubble
  logic      tbl_chain [MAX_ROWS];
  int        n_rows;
  int        prev_idx;
  logic [31:0] lfsr_state;
  // Architectural state as the table implies it
  data_t     shadow [32];

  jedro_1_datapath #(
    .REG_ADDR_WIDTH (5)
  ) dut (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Encoders and random source
  //////////////////////////////////////////////////

  function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic instr_t enc_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // Galois form, taps x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
  endfunction

  //////////////////////////////////////////////////
  // Failure and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
  endtask

  task automatic add_row(input instr_t w, input logic v, input reg_addr_t rd,
                         input data_t d, input logic chain);
    if (n_rows >= MAX_ROWS) abort_run("stimulus table is full");
    tbl_instr[n_rows] = w;
    tbl_valid[n_rows] = v;
    tbl_rd[n_rows]    = rd;
    tbl_data[n_rows]  = d;
    tbl_chain[n_rows] = chain;
    n_rows++;
  endtask

  // Trace of whatever entered one edge earlier, idx below zero is a bubble
  task automatic check_trace(input int idx);
    if (idx < 0) begin
      check_flag("wb_valid_o", wb_valid_o, 1'b0);
    end else begin
      check_flag("wb_valid_o", wb_valid_o, tbl_valid[idx]);
      if (tbl_valid[idx]) begin
        check_rd("wb_rd_o", wb_rd_o, tbl_rd[idx]);
        check_data("wb_data_o", wb_data_o, tbl_data[idx]);
        // Plain register reads must agree with the model
        if (tbl_instr[idx][6:0] == OPC_OP_IMM && tbl_instr[idx][14:12] == F3_ADD_SUB
            && tbl_instr[idx][31:20] == 12'h000) begin
          check_data("shadow model", tbl_data[idx], shadow[tbl_instr[idx][19:15]]);
        end
        if (tbl_rd[idx] != 5'd0) shadow[tbl_rd[idx]] = tbl_data[idx];
      end
    end
  endtask

  // Drive on the rising edge, check the previous slot at the falling edge
  task automatic drive_cycle(input logic v, input instr_t w, input int idx);
    @(posedge clk_i);
    instr_valid_i <= v;
    instr_i       <= w;
    @(negedge clk_i);
    check_trace(prev_idx);
    prev_idx = idx;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (wb_valid_o) begin
      if (cycles >= IDLE_TIMEOUT) begin
        abort_run("timeout while waiting for the writeback trace to go idle");
      end else begin
        cycles++;
        @(negedge clk_i);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Table contents
  //////////////////////////////////////////////////

  task automatic build_table();
    // Every register reads zero after reset
    for (int r = 0; r < 32; r++) begin
      add_row(enc_i(12'h000, reg_addr_t'(r), F3_ADD_SUB, 5'd1, OPC_OP_IMM),
              1'b1, 5'd1, 32'h0, 1'b0);
    end
    // LUI and OP-IMM
    add_row(enc_u(20'h12345, 5'd1), 1'b1, 5'd1, 32'h12345000, 1'b0);
    add_row(enc_i(12'hFFF, 5'd1, F3_ADD_SUB, 5'd2, OPC_OP_IMM), 1'b1, 5'd2, 32'h12344FFF, 1'b1);
    add_row(enc_i(12'hFFB, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM), 1'b1, 5'd3, 32'hFFFFFFFB, 1'b0);
    add_row(enc_i(12'h001, 5'd3, F3_SLT, 5'd4, OPC_OP_IMM), 1'b1, 5'd4, 32'h1, 1'b0);
    add_row(enc_i(12'h001, 5'd3, F3_SLTU, 5'd5, OPC_OP_IMM), 1'b1, 5'd5, 32'h0, 1'b0);
    add_row(enc_i(12'h0F0, 5'd3, F3_XOR, 5'd6, OPC_OP_IMM), 1'b1, 5'd6, 32'hFFFFFF0B, 1'b0);
    add_row(enc_i(12'h7FF, 5'd1, F3_OR, 5'd7, OPC_OP_IMM), 1'b1, 5'd7, 32'h123457FF, 1'b0);
    add_row(enc_i(12'h0FF, 5'd2, F3_AND, 5'd8, OPC_OP_IMM), 1'b1, 5'd8, 32'h000000FF, 1'b0);
    add_row(enc_i({7'h00, 5'd4}, 5'd3, F3_SLL, 5'd9, OPC_OP_IMM), 1'b1, 5'd9, 32'hFFFFFFB0, 1'b0);
    add_row(enc_i({7'h00, 5'd4}, 5'd3, F3_SRL_SRA, 5'd10, OPC_OP_IMM),
            1'b1, 5'd10, 32'h0FFFFFFF, 1'b0);
    add_row(enc_i({7'h20, 5'd4}, 5'd3, F3_SRL_SRA, 5'd11, OPC_OP_IMM),
            1'b1, 5'd11, 32'hFFFFFFFF, 1'b0);
    add_row(enc_u(20'h80000, 5'd12), 1'b1, 5'd12, 32'h80000000, 1'b0);
    // OP group, shifts use the low five bits of rs2
    add_row(enc_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd13), 1'b1, 5'd13, 32'h24689FFF, 1'b0);
    add_row(enc_r(7'h20, 5'd1, 5'd0, F3_ADD_SUB, 5'd14), 1'b1, 5'd14, 32'hEDCBB000, 1'b0);
    add_row(enc_r(7'h20, 5'd4, 5'd12, F3_ADD_SUB, 5'd15), 1'b1, 5'd15, 32'h7FFFFFFF, 1'b0);
    add_row(enc_r(7'h00, 5'd15, 5'd4, F3_SLL, 5'd16), 1'b1, 5'd16, 32'h80000000, 1'b1);
    add_row(enc_r(7'h00, 5'd4, 5'd3, F3_SLT, 5'd17), 1'b1, 5'd17, 32'h1, 1'b0);
    add_row(enc_r(7'h00, 5'd4, 5'd3, F3_SLTU, 5'd18), 1'b1, 5'd18, 32'h0, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd19), 1'b1, 5'd19, 32'h00001FFF, 1'b0);
    add_row(enc_r(7'h00, 5'd8, 5'd6, F3_OR, 5'd20), 1'b1, 5'd20, 32'hFFFFFFFF, 1'b0);
    add_row(enc_r(7'h00, 5'd2, 5'd7, F3_AND, 5'd21), 1'b1, 5'd21, 32'h123447FF, 1'b0);
    add_row(enc_r(7'h00, 5'd19, 5'd12, F3_SRL_SRA, 5'd22), 1'b1, 5'd22, 32'h1, 1'b0);
    add_row(enc_r(7'h20, 5'd19, 5'd12, F3_SRL_SRA, 5'd23), 1'b1, 5'd23, 32'hFFFFFFFF, 1'b0);
    add_row(enc_r(7'h20, 5'd9, 5'd1, F3_SRL_SRA, 5'd24), 1'b1, 5'd24, 32'h00001234, 1'b0);
    // Dependent chain through the bypass
    add_row(enc_i(12'h007, 5'd0, F3_ADD_SUB, 5'd25, OPC_OP_IMM), 1'b1, 5'd25, 32'h7, 1'b0);
    add_row(enc_i(12'h005, 5'd25, F3_ADD_SUB, 5'd25, OPC_OP_IMM), 1'b1, 5'd25, 32'hC, 1'b1);
    add_row(enc_r(7'h00, 5'd25, 5'd25, F3_ADD_SUB, 5'd26), 1'b1, 5'd26, 32'h18, 1'b1);
    add_row(enc_r(7'h20, 5'd25, 5'd26, F3_ADD_SUB, 5'd26), 1'b1, 5'd26, 32'hC, 1'b1);
    // x0 shows on the trace but stays zero
    add_row(enc_i(12'h001, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM), 1'b1, 5'd0, 32'h12345001, 1'b0);
    add_row(enc_i(12'h000, 5'd0, F3_ADD_SUB, 5'd27, OPC_OP_IMM), 1'b1, 5'd27, 32'h0, 1'b1);
    // Illegal encodings, then read the target back
    add_row(enc_i(12'h000, 5'd1, 3'b010, 5'd25, 7'b0000011), 1'b0, 5'd25, 32'h0, 1'b0);
    add_row(enc_i(12'h000, 5'd25, F3_ADD_SUB, 5'd28, OPC_OP_IMM), 1'b1, 5'd28, 32'hC, 1'b1);
    add_row(enc_r(7'h01, 5'd2, 5'd1, F3_ADD_SUB, 5'd26), 1'b0, 5'd26, 32'h0, 1'b0);
    add_row(enc_i(12'h000, 5'd26, F3_ADD_SUB, 5'd29, OPC_OP_IMM), 1'b1, 5'd29, 32'hC, 1'b1);
    add_row(enc_i({7'h20, 5'd1}, 5'd3, F3_SLL, 5'd9, OPC_OP_IMM), 1'b0, 5'd9, 32'h0, 1'b0);
    add_row(enc_i(12'h000, 5'd9, F3_ADD_SUB, 5'd30, OPC_OP_IMM), 1'b1, 5'd30, 32'hFFFFFFB0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int nb;
    clk_i         = 1'b0;
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    n_rows        = 0;
    prev_idx      = -1;
    lfsr_state    = 32'h2f865fc0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;
    build_table();

    // Three reset edges, trace cleared inside reset
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("wb_valid_o", wb_valid_o, 1'b0);
    check_rd("wb_rd_o", wb_rd_o, 5'd0);
    check_data("wb_data_o", wb_data_o, 32'h0);
    @(posedge clk_i);
    rstn_i <= 1'b1;
    wait_idle();

    for (int i = 0; i < n_rows; i++) begin
      nb = 0;
      // Two LFSR bits give 0 to 3 bubbles
      if (!tbl_chain[i]) begin
        for (int b = 0; b < 2; b++) begin
          nb = nb * 2 + int'(lfsr_state[0]);
          lfsr_state = lfsr_next(lfsr_state);
        end
      end
      repeat (nb) drive_cycle(1'b0, '0, -1);
      drive_cycle(1'b1, tbl_instr[i], i);
    end
    // Flush the last entry out of the pipeline
    drive_cycle(1'b0, '0, -1);
    wait_idle();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/jedro_1_pkg.sv
hdl/jedro_1_decoder.sv
hdl/jedro_1_regfile.sv
hdl/jedro_1_alu.sv
hdl/jedro_1_datapath.sv
sim/jedro_1_tb.sv

// ==== Makefile ====
# Verilator build for the jedro_1 datapath testbench

VERILATOR ?= verilator
TOP       ?= jedro_1_tb
RTL_TOP   ?= jedro_1_datapath
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) hdl/jedro_1_pkg.sv \
	  hdl/jedro_1_decoder.sv hdl/jedro_1_regfile.sv hdl/jedro_1_alu.sv \
	  hdl/jedro_1_datapath.sv

clean:
	rm -rf $(BUILD_DIR)
